// File: include/soc_cfg.svh
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

//----------------------------------------------------------
// Bus widths
//----------------------------------------------------------
// CSR word address, bank in the top 4 bits
`define CSR_ADDR_W 14
`define CSR_DATA_W 32
// Wishbone byte address
`define WB_ADDR_W 32

// Buttons in, LEDs out
`define GPIO_IN_W 4
`define GPIO_OUT_W 2

//----------------------------------------------------------
// Reset release
//----------------------------------------------------------
// Counted from the first edge with the trigger low
// Flash goes first, so the hold count must be the larger one
`define FLASH_RST_CYCLES 16
`define RST_HOLD_CYCLES 64

// CSR bank map
`define CSR_BANK_SYSCTL 1
`define CSR_BANK_TIMER 2

// Read-only identification word
`define SYSTEM_ID 32'h534f_4331

`endif

// File: rtl/soc_pkg.sv
`include "soc_cfg.svh"

package soc_pkg;

	// Bank select and register index of a CSR word address
	typedef logic [3:0] csr_bank_t;
	typedef logic [`CSR_ADDR_W-5:0] csr_reg_t;

	// CSR word address, bank field on top
	typedef struct packed {
		csr_bank_t bank;
		csr_reg_t idx;
	} csr_addr_t;

	typedef logic [`CSR_DATA_W-1:0] csr_data_t;
	typedef logic [`WB_ADDR_W-1:0] wb_addr_t;

	// Wishbone to CSR bridge FSM
	typedef enum logic [1:0] {
		IDLE,
		ACCESS,
		READ,
		ACK
	} bridge_state_e;

	// System controller register map
	typedef enum csr_reg_t {
		GPIO_IN = 0,
		GPIO_OUT = 1,
		IRQ_EN = 2,
		SYSTEM_ID = 3,
		HARD_RESET = 4
	} sysctl_reg_e;

	// Timer register map
	typedef enum csr_reg_t {
		CONTROL = 0,
		COMPARE = 1,
		COUNTER = 2
	} timer_reg_e;

endpackage

// File: rtl/csr_if.sv
`timescale 1ns/1ps

// CSR bus shared by the bridge and all slaves
// Read data is not part of it, every slave has its own line
interface csr_if import soc_pkg::*; ();

	// Word address, valid for the single access cycle
	csr_addr_t csr_a;
	// Write strobe, high for one cycle on writes only
	logic csr_we;
	// Write data
	csr_data_t csr_dw;

	modport bridge (
		output csr_a,
		output csr_we,
		output csr_dw
	);

	modport slave (
		input csr_a,
		input csr_we,
		input csr_dw
	);

endinterface

// File: rtl/reset_sequencer.sv
`timescale 1ns/1ps
`include "soc_cfg.svh"

module reset_sequencer (
	input logic sys_clk,
	input logic trigger_reset,
	input logic hard_reset_req_i,
	output logic sys_rst_o,
	output logic flash_rst_n_o
);

	localparam int hold_w = $clog2(`RST_HOLD_CYCLES + 1);
	localparam int flash_w = $clog2(`FLASH_RST_CYCLES + 1);

	logic restart;
	logic [hold_w-1:0] hold_cnt;
	logic [flash_w-1:0] flash_cnt;

	// Pin reset or software request, both restart the sequence
	assign restart = trigger_reset | hard_reset_req_i;

	//----------------------------------------------------------
	// Hold counters
	//----------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (restart) begin
			hold_cnt <= hold_w'(`RST_HOLD_CYCLES);
			flash_cnt <= flash_w'(`FLASH_RST_CYCLES);
		end else begin
			// Count down and stop at zero
			if (hold_cnt != '0)
				hold_cnt <= hold_cnt - 1'b1;
			if (flash_cnt != '0)
				flash_cnt <= flash_cnt - 1'b1;
		end
	end

	// Registered outputs, one edge behind the counters
	// Flash leaves reset first, it must be readable before boot
	always_ff @(posedge sys_clk) begin
		sys_rst_o <= (hold_cnt != '0);
		flash_rst_n_o <= (flash_cnt == '0);
	end

endmodule

// File: rtl/wb_csr_bridge.sv
`timescale 1ns/1ps

module wb_csr_bridge import soc_pkg::*; (
	input logic sys_clk,
	input logic sys_rst_i,

	// Wishbone slave side
	input wb_addr_t wb_adr_i,
	input csr_data_t wb_dat_i,
	output csr_data_t wb_dat_o,
	input logic wb_we_i,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	output logic wb_ack_o,

	// CSR master side
	input csr_data_t csr_dr_i,
	csr_if.bridge csr
);

	bridge_state_e state;
	logic req;
	logic accept;

	// Ack still high means the master has not dropped stb yet
	assign req = wb_cyc_i & wb_stb_i & ~wb_ack_o;
	assign accept = (state == IDLE) & req;

	//----------------------------------------------------------
	// FSM
	//----------------------------------------------------------
	// IDLE -> ACCESS (CSR cycle) -> READ (latch data) -> ACK
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			state <= IDLE;
			wb_ack_o <= 1'b0;
			csr.csr_we <= 1'b0;
		end else begin
			// Both strobes are single-cycle pulses
			wb_ack_o <= 1'b0;
			csr.csr_we <= 1'b0;
			case (state)
				IDLE: begin
					if (req) begin
						state <= ACCESS;
						// Write strobe lines up with ACCESS
						csr.csr_we <= wb_we_i;
					end
				end
				ACCESS: begin
					state <= READ;
				end
				READ: begin
					state <= ACK;
				end
				ACK: begin
					wb_ack_o <= 1'b1;
					state <= IDLE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	//----------------------------------------------------------
	// Datapath
	//----------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		// Byte address to word address
		if (accept) begin
			csr.csr_a <= wb_adr_i[$bits(csr_addr_t)+1:2];
			csr.csr_dw <= wb_dat_i;
		end
		// Slaves registered their data at the end of ACCESS
		if (state == READ)
			wb_dat_o <= csr_dr_i;
	end

endmodule

// File: rtl/sysctl_gpio.sv
`timescale 1ns/1ps
`include "soc_cfg.svh"

module sysctl_gpio import soc_pkg::*; #(
	parameter csr_bank_t csr_bank = 4'd0
) (
	input logic sys_clk,
	input logic sys_rst_i,

	csr_if.slave csr,
	output csr_data_t csr_dr_o,

	input logic [`GPIO_IN_W-1:0] btn_i,
	output logic [`GPIO_OUT_W-1:0] led_o,
	output logic irq_o,
	output logic hard_reset_req_o
);

	logic [`GPIO_IN_W-1:0] btn_meta;
	logic [`GPIO_IN_W-1:0] btn_sync;
	logic [`GPIO_IN_W-1:0] btn_prev;
	logic [`GPIO_IN_W-1:0] irq_en;
	logic sel;

	// Bank decode
	assign sel = (csr.csr_a.bank == csr_bank);

	//----------------------------------------------------------
	// Button inputs
	//----------------------------------------------------------
	// Two-flop synchronizer, third flop keeps the last value
	always_ff @(posedge sys_clk) begin
		btn_meta <= btn_i;
		btn_sync <= btn_meta;
		btn_prev <= btn_sync;
	end

	//----------------------------------------------------------
	// Registers and strobes
	//----------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			led_o <= '0;
			irq_en <= '0;
			irq_o <= 1'b0;
			hard_reset_req_o <= 1'b0;
		end else begin
			// One pulse per enabled input change
			irq_o <= |((btn_sync ^ btn_prev) & irq_en);
			hard_reset_req_o <= 1'b0;
			if (sel && csr.csr_we) begin
				case (csr.csr_a.idx)
					GPIO_OUT: led_o <= csr.csr_dw[`GPIO_OUT_W-1:0];
					IRQ_EN: irq_en <= csr.csr_dw[`GPIO_IN_W-1:0];
					// Written value does not matter
					HARD_RESET: hard_reset_req_o <= 1'b1;
					// GPIO_IN and SYSTEM_ID are read-only
					default: ;
				endcase
			end
		end
	end

	// Read data, zero unless this bank is read
	always_ff @(posedge sys_clk) begin
		csr_dr_o <= '0;
		if (sel && !csr.csr_we) begin
			case (csr.csr_a.idx)
				GPIO_IN: csr_dr_o <= csr_data_t'(btn_sync);
				GPIO_OUT: csr_dr_o <= csr_data_t'(led_o);
				IRQ_EN: csr_dr_o <= csr_data_t'(irq_en);
				SYSTEM_ID: csr_dr_o <= `SYSTEM_ID;
				default: csr_dr_o <= '0;
			endcase
		end
	end

endmodule

// File: rtl/csr_timer.sv
`timescale 1ns/1ps
`include "soc_cfg.svh"

module csr_timer import soc_pkg::*; #(
	parameter csr_bank_t csr_bank = 4'd0
) (
	input logic sys_clk,
	input logic sys_rst_i,

	csr_if.slave csr,
	output csr_data_t csr_dr_o,

	output logic irq_o
);

	logic en;
	logic auto_restart;
	logic [`CSR_DATA_W-1:0] compare;
	logic [`CSR_DATA_W-1:0] count;
	logic sel;
	logic wr;

	// Bank decode
	assign sel = (csr.csr_a.bank == csr_bank);
	assign wr = sel & csr.csr_we;

	//----------------------------------------------------------
	// Counter and interrupt
	//----------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			en <= 1'b0;
			auto_restart <= 1'b0;
			compare <= '0;
			count <= '0;
			irq_o <= 1'b0;
		end else begin
			irq_o <= 1'b0;
			if (en) begin
				if (count == compare) begin
					// Wrap and flag, one-shot stops here
					count <= '0;
					irq_o <= 1'b1;
					if (!auto_restart)
						en <= 1'b0;
				end else begin
					count <= count + 1'b1;
				end
			end
			// Bus writes win over counting
			if (wr) begin
				case (csr.csr_a.idx)
					CONTROL: begin
						en <= csr.csr_dw[0];
						auto_restart <= csr.csr_dw[1];
					end
					COMPARE: compare <= csr.csr_dw;
					COUNTER: count <= csr.csr_dw;
					default: ;
				endcase
			end
		end
	end

	// Read data, zero unless this bank is read
	always_ff @(posedge sys_clk) begin
		csr_dr_o <= '0;
		if (sel && !csr.csr_we) begin
			case (csr.csr_a.idx)
				CONTROL: csr_dr_o <= csr_data_t'({auto_restart, en});
				COMPARE: csr_dr_o <= compare;
				COUNTER: csr_dr_o <= count;
				default: csr_dr_o <= '0;
			endcase
		end
	end

endmodule

// File: rtl/soc_top.sv
`timescale 1ns/1ps
`include "soc_cfg.svh"

module soc_top import soc_pkg::*; (
	input logic sys_clk,
	input logic trigger_reset,

	// Wishbone slave, driven by the external master
	input wb_addr_t wb_adr_i,
	input csr_data_t wb_dat_i,
	output csr_data_t wb_dat_o,
	input logic wb_we_i,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	output logic wb_ack_o,

	// GPIO
	input logic [`GPIO_IN_W-1:0] btn_i,
	output logic [`GPIO_OUT_W-1:0] led_o,

	// Interrupts
	output logic gpio_irq_o,
	output logic timer_irq_o,

	// Off-chip resets
	output logic flash_rst_n_o,
	output logic periph_rst_n_o
);

	logic sys_rst;
	logic hard_reset_req;
	csr_data_t csr_dr_sysctl;
	csr_data_t csr_dr_timer;
	csr_data_t csr_dr;

	csr_if csr_bus ();

	// Unselected slaves drive zero, so OR is enough
	assign csr_dr = csr_dr_sysctl | csr_dr_timer;
	assign periph_rst_n_o = ~sys_rst;

	//----------------------------------------------------------
	// Reset and bridge
	//----------------------------------------------------------
	reset_sequencer i_reset_seq (
		.sys_clk(sys_clk),
		.trigger_reset(trigger_reset),
		.hard_reset_req_i(hard_reset_req),
		.sys_rst_o(sys_rst),
		.flash_rst_n_o(flash_rst_n_o)
	);

	wb_csr_bridge i_bridge (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst),
		.wb_adr_i(wb_adr_i),
		.wb_dat_i(wb_dat_i),
		.wb_dat_o(wb_dat_o),
		.wb_we_i(wb_we_i),
		.wb_cyc_i(wb_cyc_i),
		.wb_stb_i(wb_stb_i),
		.wb_ack_o(wb_ack_o),
		.csr_dr_i(csr_dr),
		.csr(csr_bus.bridge)
	);

	//----------------------------------------------------------
	// CSR slaves
	//----------------------------------------------------------
	sysctl_gpio #(
		.csr_bank(csr_bank_t'(`CSR_BANK_SYSCTL))
	) i_sysctl (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst),
		.csr(csr_bus.slave),
		.csr_dr_o(csr_dr_sysctl),
		.btn_i(btn_i),
		.led_o(led_o),
		.irq_o(gpio_irq_o),
		.hard_reset_req_o(hard_reset_req)
	);

	csr_timer #(
		.csr_bank(csr_bank_t'(`CSR_BANK_TIMER))
	) i_timer (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst),
		.csr(csr_bus.slave),
		.csr_dr_o(csr_dr_timer),
		.irq_o(timer_irq_o)
	);

endmodule

// File: dv/tb_soc_top.sv
`timescale 1ns/1ps
`include "soc_cfg.svh"

module tb_soc_top import soc_pkg::*; ();

	localparam int max_vecs = 64;
	localparam int ack_bound = 8;
	localparam int gpio_irq_bound = 20;
	localparam int timer_irq_bound = 100;
	localparam logic [31:0] btn_mask = (32'd1 << `GPIO_IN_W) - 1;
	localparam logic [31:0] led_mask = (32'd1 << `GPIO_OUT_W) - 1;
	// GPIO_OUT byte address with the bank in bits 15:12 and index 1
	localparam logic [31:0] led_adr = (32'(`CSR_BANK_SYSCTL) << 12) | 32'h4;

	logic sys_clk;
	logic trigger_reset;
	wb_addr_t wb_adr_i;
	csr_data_t wb_dat_i;
	csr_data_t wb_dat_o;
	logic wb_we_i;
	logic wb_cyc_i;
	logic wb_stb_i;
	logic wb_ack_o;
	logic [`GPIO_IN_W-1:0] btn_i;
	logic [`GPIO_OUT_W-1:0] led_o;
	logic gpio_irq_o;
	logic timer_irq_o;
	logic flash_rst_n_o;
	logic periph_rst_n_o;

	// Vector table
	logic [7:0] vec_op [0:max_vecs-1];
	logic [31:0] vec_adr [0:max_vecs-1];
	logic [31:0] vec_dat [0:max_vecs-1];
	logic [31:0] vec_msk [0:max_vecs-1];
	string vec_name [0:max_vecs-1];
	int vec_count;
	int cycle_cnt = 0;
	int cycle_limit = 500;

	soc_top i_dut (
		.sys_clk(sys_clk),
		.trigger_reset(trigger_reset),
		.wb_adr_i(wb_adr_i),
		.wb_dat_i(wb_dat_i),
		.wb_dat_o(wb_dat_o),
		.wb_we_i(wb_we_i),
		.wb_cyc_i(wb_cyc_i),
		.wb_stb_i(wb_stb_i),
		.wb_ack_o(wb_ack_o),
		.btn_i(btn_i),
		.led_o(led_o),
		.gpio_irq_o(gpio_irq_o),
		.timer_irq_o(timer_irq_o),
		.flash_rst_n_o(flash_rst_n_o),
		.periph_rst_n_o(periph_rst_n_o)
	);

	// 4 ns clock
	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;
	end

	//----------------------------------------------------------
	// Watchdog
	//----------------------------------------------------------
	always @(posedge sys_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > cycle_limit) begin
			$display("Timeout after %0d cycles, run did not complete", cycle_cnt);
			$display("STATUS: FAIL");
			$fatal(1, "Timeout");
		end
	end

	//----------------------------------------------------------
	// Reporting and checks
	//----------------------------------------------------------
	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1, "Run stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else
			stop_with_failure($sformatf("CHECK FAILED %s expected %h actual %h",
				name, expected, actual));
	endtask

	//----------------------------------------------------------
	// Vector file
	//----------------------------------------------------------
	task automatic load_vectors();
		int fd;
		int code;
		string line;
		string nm;
		logic [7:0] op;
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] m;
		fd = $fopen("dv/soc_vectors.txt", "r");
		assert (fd != 0) else
			stop_with_failure("Cannot open the vector file dv/soc_vectors.txt");
		vec_count = 0;
		while (!$feof(fd)) begin
			code = $fgets(line, fd);
			if (code > 0) begin
				code = $sscanf(line, "%c %h %h %h %s", op, a, d, m, nm);
				// Comment and blank lines fall out here
				if (code == 5 && op != "#") begin
					assert (vec_count < max_vecs) else
						stop_with_failure("Vector file has more lines than the table holds");
					vec_op[vec_count] = op;
					vec_adr[vec_count] = a;
					vec_dat[vec_count] = d;
					vec_msk[vec_count] = m;
					vec_name[vec_count] = nm;
					vec_count++;
				end
			end
		end
		$fclose(fd);
		cycle_limit = vec_count * 200 + 500;
	endtask

	//----------------------------------------------------------
	// Bus and wait helpers
	//----------------------------------------------------------
	// One classic single-beat cycle with the request held until ack
	task automatic wb_cycle(input logic we, input logic [31:0] adr, input logic [31:0] wdat,
			output logic [31:0] rdat, input string name);
		int n;
		@(negedge sys_clk);
		wb_adr_i = adr;
		wb_dat_i = wdat;
		wb_we_i = we;
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		n = 0;
		do begin
			@(negedge sys_clk);
			n++;
		end while (wb_ack_o !== 1'b1 && n < ack_bound);
		assert (wb_ack_o === 1'b1) else
			stop_with_failure($sformatf("%s: no Wishbone ack within %0d cycles",
				name, ack_bound));
		rdat = wb_dat_o;
		// Stb is already low at the next edge
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
	endtask

	// Src 0 is gpio and 1 is timer
	// Pulses last one cycle and are sampled mid-cycle
	task automatic wait_irq(input int src, input logic expect_pulse, input int bound,
			input string name);
		int n;
		logic seen;
		n = 0;
		seen = 1'b0;
		while (n < bound && !(seen && expect_pulse)) begin
			@(negedge sys_clk);
			n++;
			if ((src == 0 && gpio_irq_o === 1'b1) || (src == 1 && timer_irq_o === 1'b1))
				seen = 1'b1;
		end
		assert (seen == expect_pulse) else
			stop_with_failure(expect_pulse ?
				$sformatf("%s: no interrupt pulse within %0d cycles", name, bound) :
				$sformatf("%s: interrupt pulse although the input is masked", name));
	endtask

	// Entered mid-cycle right after the first edge with the restart low
	task automatic measure_release(input string name);
		int k;
		int flash_k;
		int periph_k;
		k = 0;
		flash_k = -1;
		periph_k = -1;
		assert (flash_rst_n_o === 1'b0 && periph_rst_n_o === 1'b0) else
			stop_with_failure($sformatf("%s: resets not asserted when release starts", name));
		while (periph_k < 0 && k < `RST_HOLD_CYCLES + 32) begin
			@(negedge sys_clk);
			k++;
			if (flash_k < 0 && flash_rst_n_o === 1'b1) begin
				flash_k = k;
				// Flash must leave reset ahead of the system
				assert (periph_rst_n_o === 1'b0) else
					stop_with_failure($sformatf("%s: peripheral reset released with flash", name));
			end
			if (periph_rst_n_o === 1'b1)
				periph_k = k;
		end
		assert (periph_k >= 0) else
			stop_with_failure($sformatf("%s: peripheral reset never released", name));
		check_value({name, "_flash_cycles"}, `FLASH_RST_CYCLES, 32'(flash_k));
		check_value({name, "_periph_cycles"}, `RST_HOLD_CYCLES, 32'(periph_k));
	endtask

	//----------------------------------------------------------
	// One vector line
	//----------------------------------------------------------
	task automatic run_vector(input int idx);
		logic [31:0] rdat;
		logic [31:0] pattern;
		logic [31:0] rnd;
		string name;
		name = vec_name[idx];
		case (vec_op[idx])
			"W": wb_cycle(1'b1, vec_adr[idx], vec_dat[idx], rdat, name);
			"R": begin
				wb_cycle(1'b0, vec_adr[idx], '0, rdat, name);
				check_value(name, vec_dat[idx], rdat);
			end
			"B": begin
				// Masked bits random and the rest from the data column
				pattern = ((vec_dat[idx] & ~vec_msk[idx]) | ($urandom & vec_msk[idx])) & btn_mask;
				@(negedge sys_clk);
				btn_i = pattern[`GPIO_IN_W-1:0];
				// Past the two-flop synchronizer
				repeat (4) @(negedge sys_clk);
				wb_cycle(1'b0, vec_adr[idx], '0, rdat, name);
				check_value(name, pattern, rdat);
			end
			"I": begin
				if (vec_adr[idx] == 32'd0) begin
					@(negedge sys_clk);
					btn_i = vec_dat[idx][`GPIO_IN_W-1:0];
					wait_irq(0, vec_msk[idx][0], gpio_irq_bound, name);
				end else begin
					wait_irq(1, vec_msk[idx][0], timer_irq_bound, name);
				end
			end
			"X": begin
				rnd = $urandom;
				wb_cycle(1'b1, vec_adr[idx], rnd, rdat, name);
				wb_cycle(1'b0, vec_adr[idx], '0, rdat, name);
				check_value(name, rnd & vec_msk[idx], rdat);
				if (vec_adr[idx] == led_adr)
					check_value({name, "_led"}, rnd & led_mask, 32'(led_o));
			end
			"H": begin
				// Resets drop at the ack edge and release is counted from there
				wb_cycle(1'b1, vec_adr[idx], vec_dat[idx], rdat, name);
				measure_release(name);
				check_value({name, "_led"}, 32'd0, 32'(led_o));
			end
			default: begin
				stop_with_failure($sformatf("Unknown operation in vector line %0d", idx));
			end
		endcase
	endtask

	//----------------------------------------------------------
	// Main sequence
	//----------------------------------------------------------
	initial begin
		trigger_reset = 1'b1;
		wb_adr_i = '0;
		wb_dat_i = '0;
		wb_we_i = 1'b0;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		btn_i = '0;
		void'($urandom(32'h9a06));
		load_vectors();

		// Power-on reset for 16 cycles
		repeat (16) @(negedge sys_clk);
		trigger_reset = 1'b0;
		// First edge with the trigger sampled low
		@(posedge sys_clk);
		@(negedge sys_clk);
		measure_release("por_release");

		for (int i = 0; i < vec_count; i++)
			run_vector(i);

		$display("STATUS: PASS");
		$finish;
	end

endmodule

// File: soc_top.f
+incdir+include
rtl/soc_pkg.sv
rtl/csr_if.sv
rtl/reset_sequencer.sv
rtl/wb_csr_bridge.sv
rtl/sysctl_gpio.sv
rtl/csr_timer.sv
rtl/soc_top.sv
dv/tb_soc_top.sv

// File: Bender.yml
package:
  name: soc_top

sources:
  - include_dirs:
      - include
    files:
      - rtl/soc_pkg.sv
      - rtl/csr_if.sv
      - rtl/reset_sequencer.sv
      - rtl/wb_csr_bridge.sv
      - rtl/sysctl_gpio.sv
      - rtl/csr_timer.sv
      - rtl/soc_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/tb_soc_top.sv

// File: dv/soc_vectors.txt
# op addr data mask name, all numbers hex
# W write, R read and compare, B buttons, I irq (addr 0 gpio, 1 timer), H hard reset, X random
R 0000100c 534f4331 0 sysid_read
R 00001014 00000000 0 sysctl_unused_reg
R 00000000 00000000 0 bank0_reg0
R 00000008 00000000 0 bank0_reg2
R 00003000 00000000 0 bank3_reg0
R 00003004 00000000 0 bank3_reg1
R 00003008 00000000 0 bank3_reg2
R 0000300c 00000000 0 bank3_reg3
R 00003010 00000000 0 bank3_reg4
X 00001004 00000000 00000003 gpio_out_rand
X 00002004 00000000 ffffffff compare_rand
X 00002008 00000000 ffffffff counter_rand
B 00001000 00000000 0000000f btn_rand
B 00001000 00000000 00000000 btn_clear
W 00001008 00000001 0 irq_en_bit0
R 00001008 00000001 0 irq_en_read
I 00000000 00000001 1 gpio_irq_enabled
I 00000000 00000003 0 gpio_irq_masked
W 00002004 00000010 0 timer_compare
W 00002008 00000000 0 timer_counter_clear
W 00002000 00000001 0 timer_oneshot_start
I 00000001 00000000 1 timer_oneshot_irq
R 00002000 00000000 0 timer_oneshot_ctrl
W 00002000 00000003 0 timer_auto_start
I 00000001 00000000 1 timer_auto_irq1
I 00000001 00000000 1 timer_auto_irq2
R 00002000 00000003 0 timer_auto_ctrl
W 00002000 00000000 0 timer_stop
W 00001004 00000002 0 led_set
R 00001004 00000002 0 led_read
H 00001010 00000001 0 hard_reset
R 00001004 00000000 0 gpio_out_after_reset
